// ==== mazePkg.sv ====
package mazePkg;

	// waypoints of the maze, wpNone marks a missing edge
	typedef enum logic [4:0] {
		wpNone, wpS1, wpS2, wpS3, wpS4, wpS5, wpS6, wpS7, wpS8, wpS9, wpS10,
		wpS11, wpS12, wpS13, wpS14, wpS15, wpS16, wpS17, wpS18, wpS19, wpS20
	} waypoint_t;

	// column order of the edge table follows this encoding
	typedef enum logic [2:0] {
		dirNone,
		dirLeft,
		dirUp,
		dirRight,
		dirDown
	} direction_t;

	localparam int stepWidth = 7;
	typedef logic [stepWidth-1:0] stepCount_t;

	// one corridor: where it leads and how many pixels long it is
	typedef struct packed {
		waypoint_t target;
		stepCount_t length;
	} edge_t;

	// navigator to drawer
	typedef struct packed {
		direction_t dir;
		logic home;
	} moveCmd_t;

	localparam edge_t noEdge = '{wpNone, 7'd0};

	// rows by waypoint, columns none / left / up / right / down
	localparam edge_t mazeEdges [21][5] = '{
		'{noEdge, noEdge, noEdge, noEdge, noEdge},
		'{noEdge, noEdge, noEdge, '{wpS2, 7'd24}, noEdge},
		'{noEdge, '{wpS1, 7'd24}, noEdge, noEdge, '{wpS3, 7'd14}},
		'{noEdge, noEdge, '{wpS2, 7'd14}, '{wpS4, 7'd22}, noEdge},
		'{noEdge, '{wpS3, 7'd22}, '{wpS5, 7'd26}, noEdge, noEdge},
		'{noEdge, '{wpS6, 7'd22}, noEdge, noEdge, '{wpS4, 7'd26}},
		'{noEdge, noEdge, '{wpS7, 7'd14}, '{wpS5, 7'd22}, noEdge},
		'{noEdge, noEdge, noEdge, '{wpS8, 7'd44}, '{wpS6, 7'd14}},
		'{noEdge, '{wpS7, 7'd44}, noEdge, noEdge, '{wpS9, 7'd28}},
		'{noEdge, noEdge, '{wpS8, 7'd28}, '{wpS10, 7'd22}, noEdge},
		'{noEdge, '{wpS9, 7'd22}, noEdge, noEdge, '{wpS11, 7'd13}},
		'{noEdge, '{wpS12, 7'd22}, '{wpS10, 7'd13}, noEdge, noEdge},
		'{noEdge, noEdge, noEdge, '{wpS11, 7'd22}, '{wpS13, 7'd14}},
		'{noEdge, '{wpS14, 7'd46}, '{wpS12, 7'd14}, '{wpS15, 7'd44}, noEdge},
		'{noEdge, noEdge, noEdge, '{wpS13, 7'd46}, noEdge},
		'{noEdge, '{wpS13, 7'd44}, '{wpS16, 7'd28}, noEdge, noEdge},
		'{noEdge, noEdge, '{wpS17, 7'd28}, '{wpS20, 7'd30}, '{wpS15, 7'd28}},
		'{noEdge, '{wpS18, 7'd20}, noEdge, noEdge, '{wpS16, 7'd28}},
		'{noEdge, noEdge, noEdge, '{wpS17, 7'd20}, '{wpS19, 7'd10}},
		'{noEdge, noEdge, '{wpS18, 7'd10}, noEdge, noEdge},
		'{noEdge, noEdge, noEdge, noEdge, noEdge}
	};

	// true when a corridor leaves wp in direction dir
	function automatic logic hasEdge(waypoint_t wp, direction_t dir);
		return mazeEdges[wp][dir].target != wpNone;
	endfunction

endpackage

// ==== pixelPkg.sv ====
package pixelPkg;

	// screen is 160 x 120
	typedef logic [7:0] xCoord_t;
	typedef logic [6:0] yCoord_t;
	typedef logic [2:0] color_t;

	// rgb, one bit each
	localparam color_t colorBlock = 3'b100;
	localparam color_t colorErase = 3'b111;

	// top-left corner of the block at the start waypoint
	localparam xCoord_t homeX = 8'd8;
	localparam yCoord_t homeY = 7'd76;

	typedef struct packed {
		xCoord_t x;
		yCoord_t y;
		color_t color;
	} pixel_t;

	// decoded position inside the frame
	typedef struct packed {
		logic stepTick;
		logic draw;
		logic [1:0] drawIndex;
		logic frameEnd;
	} frameSlot_t;

endpackage

// ==== frameTimer.sv ====
`timescale 1ns/1ps

module frameTimer
	import pixelPkg::*;
#(
	parameter int framePeriod = 1000000
) (
	input logic clk,
	input logic reset,
	input logic run,
	output frameSlot_t slot
);

	localparam int countWidth = $clog2(framePeriod);
	localparam logic [countWidth-1:0] lastCount = countWidth'(framePeriod - 1);

	logic [countWidth-1:0] frameCount;

	// counts down to zero, then starts the next frame
	always_ff @(posedge clk) begin
		if (reset || !run || frameCount == '0) begin
			frameCount <= lastCount;
		end else begin
			frameCount <= frameCount - 1'b1;
		end
	end

	// slot decode near the bottom of the count
	always_comb begin
		slot = '0;
		if (run) begin
			// block moves before anything is drawn
			slot.stepTick = (frameCount == countWidth'(6));
			slot.frameEnd = (frameCount == '0);
			// counts 4 down to 1 give draw slots 0 to 3
			if (frameCount >= countWidth'(1) && frameCount <= countWidth'(4)) begin
				slot.draw = 1'b1;
				slot.drawIndex = 2'(countWidth'(4) - frameCount);
			end
		end
	end

endmodule

// ==== mazeNavigator.sv ====
`timescale 1ns/1ps

module mazeNavigator
	import mazePkg::*, pixelPkg::*;
(
	input logic clk,
	input logic reset,
	input logic left,
	input logic up,
	input logic right,
	input logic down,
	input frameSlot_t slot,
	output logic run,
	output moveCmd_t cmd
);

	typedef enum logic [1:0] {
		parked,
		waitRelease,
		moving
	} navState_t;

	navState_t state;
	waypoint_t waypoint;
	direction_t moveDir;
	edge_t curEdge;
	stepCount_t stepCount;

	direction_t pickDir;
	logic buttonHeld;
	logic startMove;
	logic arrived;

	// fixed priority right, up, left, down
	// only buttons with a corridor count
	always_comb begin
		pickDir = dirNone;
		if (waypoint != wpS20) begin
			if (right && hasEdge(waypoint, dirRight)) begin
				pickDir = dirRight;
			end else if (up && hasEdge(waypoint, dirUp)) begin
				pickDir = dirUp;
			end else if (left && hasEdge(waypoint, dirLeft)) begin
				pickDir = dirLeft;
			end else if (down && hasEdge(waypoint, dirDown)) begin
				pickDir = dirDown;
			end
		end
	end

	// level of the button that was latched
	always_comb begin
		case (moveDir)
			dirLeft: buttonHeld = left;
			dirUp: buttonHeld = up;
			dirRight: buttonHeld = right;
			dirDown: buttonHeld = down;
			default: buttonHeld = 1'b0;
		endcase
	end

	// at home the timer keeps running
	// so the move waits for the frame boundary
	// elsewhere the timer is held and the move starts at once
	assign startMove = !buttonHeld && (slot.frameEnd || !run);

	// whole edge covered
	assign arrived = (stepCount == curEdge.length);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= parked;
			waypoint <= wpS1;
			moveDir <= dirNone;
			stepCount <= '0;
		end else begin
			case (state)
				parked: begin
					if (pickDir != dirNone) begin
						state <= waitRelease;
						moveDir <= pickDir;
					end
				end
				waitRelease: begin
					if (startMove) begin
						state <= moving;
						stepCount <= '0;
					end
				end
				moving: begin
					if (arrived) begin
						state <= parked;
						waypoint <= curEdge.target;
						moveDir <= dirNone;
					end else if (slot.frameEnd) begin
						// one step per frame
						stepCount <= stepCount + 1'b1;
					end
				end
				default: begin
					state <= parked;
				end
			endcase
		end
	end

	// corridor taken from the table when a button is latched
	always_ff @(posedge clk) begin
		if (state == parked && pickDir != dirNone) begin
			curEdge <= mazeEdges[waypoint][pickDir];
		end
	end

	// timer paces home redraws and moves only
	assign run = (waypoint == wpS1) || (state == moving);

	// home stays up while a button is held at the start
	assign cmd.home = (waypoint == wpS1) && (state != moving);
	assign cmd.dir = (state == moving) ? moveDir : dirNone;

endmodule

// ==== blockDrawer.sv ====
`timescale 1ns/1ps

module blockDrawer
	import mazePkg::*, pixelPkg::*;
(
	input logic clk,
	input logic reset,
	input frameSlot_t slot,
	input moveCmd_t cmd,
	output pixel_t pix,
	output logic plot
);

	// top-left corner of the 2x2 block
	xCoord_t blockX;
	yCoord_t blockY;

	// columns and rows around the block
	xCoord_t xLeft;
	xCoord_t xRight;
	xCoord_t xPast;
	yCoord_t yAbove;
	yCoord_t yBottom;
	yCoord_t yBelow;

	pixel_t nextPix;
	logic drawing;

	assign xLeft = blockX - 8'd1;
	assign xRight = blockX + 8'd1;
	assign xPast = blockX + 8'd2;
	assign yAbove = blockY - 7'd1;
	assign yBottom = blockY + 7'd1;
	assign yBelow = blockY + 7'd2;

	// one pixel per step tick, up is toward row 0
	always_ff @(posedge clk) begin
		if (reset || cmd.home) begin
			blockX <= homeX;
			blockY <= homeY;
		end else if (slot.stepTick) begin
			case (cmd.dir)
				dirLeft: blockX <= xLeft;
				dirRight: blockX <= xRight;
				dirUp: blockY <= yAbove;
				dirDown: blockY <= yBottom;
				default: blockX <= blockX;
			endcase
		end
	end

	// pixel for the current draw slot
	always_comb begin
		// home block: bit 0 picks the column and bit 1 the row
		nextPix.x = slot.drawIndex[0] ? xRight : blockX;
		nextPix.y = slot.drawIndex[1] ? yBottom : blockY;
		nextPix.color = colorBlock;
		if (!cmd.home) begin
			// slots 2 and 3 wipe the edge just left behind
			if (slot.drawIndex[1]) begin
				nextPix.color = colorErase;
			end
			case (cmd.dir)
				dirRight: begin
					nextPix.x = slot.drawIndex[1] ? xLeft : xRight;
					nextPix.y = slot.drawIndex[0] ? yBottom : blockY;
				end
				dirLeft: begin
					nextPix.x = slot.drawIndex[1] ? xPast : blockX;
					nextPix.y = slot.drawIndex[0] ? yBottom : blockY;
				end
				dirDown: begin
					nextPix.x = slot.drawIndex[0] ? xRight : blockX;
					nextPix.y = slot.drawIndex[1] ? yAbove : yBottom;
				end
				dirUp: begin
					nextPix.x = slot.drawIndex[0] ? xRight : blockX;
					nextPix.y = slot.drawIndex[1] ? yBelow : blockY;
				end
				default: begin
					nextPix.color = colorBlock;
				end
			endcase
		end
	end

	// nothing to draw while parked away from home
	assign drawing = cmd.home || (cmd.dir != dirNone);

	always_ff @(posedge clk) begin
		if (reset) begin
			plot <= 1'b0;
		end else begin
			plot <= slot.draw && drawing;
		end
	end

	always_ff @(posedge clk) begin
		if (slot.draw) begin
			pix <= nextPix;
		end
	end

endmodule

// ==== mazeGame.sv ====
`timescale 1ns/1ps

module mazeGame
	import mazePkg::*, pixelPkg::*;
#(
	// cycles per frame, 50 Hz frames at 50 MHz by default
	parameter int framePeriod = 1000000
) (
	input logic clk,
	input logic reset,
	input logic left,
	input logic up,
	input logic right,
	input logic down,
	output pixel_t pix,
	output logic plot
);

	frameSlot_t slot;
	logic run;
	moveCmd_t cmd;

	// frame pacing
	frameTimer #(
		.framePeriod(framePeriod)
	) timer_i (
		.clk(clk),
		.reset(reset),
		.run(run),
		.slot(slot)
	);

	// waypoint walk driven by the buttons
	mazeNavigator navigator_i (
		.clk(clk),
		.reset(reset),
		.left(left),
		.up(up),
		.right(right),
		.down(down),
		.slot(slot),
		.run(run),
		.cmd(cmd)
	);

	// block position and pixel stream
	blockDrawer drawer_i (
		.clk(clk),
		.reset(reset),
		.slot(slot),
		.cmd(cmd),
		.pix(pix),
		.plot(plot)
	);

endmodule

// ==== mazeGameTbTable.svh ====
`ifndef MAZE_GAME_TB_TABLE_SVH
`define MAZE_GAME_TB_TABLE_SVH

// columns are button, minimum hold in cycles, corridor expected, corner x and corner y
// random extra hold is added on top of the minimum in the run loop
localparam int rowCount = 8;

localparam pathRow_t pathTable [rowCount] = '{
	// S1 to S2 with a long hold that keeps home redraws going
	'{button: dirRight, holdMin: 40, moves: 1'b1, expX: 32, expY: 76},
	// back to the start where home redraws resume
	'{button: dirLeft, holdMin: 4, moves: 1'b1, expX: 8, expY: 76},
	'{button: dirRight, holdMin: 24, moves: 1'b1, expX: 32, expY: 76},
	// S2 to S3
	'{button: dirDown, holdMin: 4, moves: 1'b1, expX: 32, expY: 90},
	// no corridor to the left of S3
	'{button: dirLeft, holdMin: 6, moves: 1'b0, expX: 32, expY: 90},
	// S3 to S4
	'{button: dirRight, holdMin: 5, moves: 1'b1, expX: 54, expY: 90},
	// S4 to S5
	'{button: dirUp, holdMin: 3, moves: 1'b1, expX: 54, expY: 64},
	// S5 to S6
	'{button: dirLeft, holdMin: 8, moves: 1'b1, expX: 32, expY: 64}
};

`endif

// ==== mazeGameTb.sv ====
`timescale 1ns/1ps

module mazeGameTb
	import mazePkg::*, pixelPkg::*;
();

	localparam int framePeriod = 16;
	// longest corridor plus slack for frame alignment
	localparam int moveTimeout = 64 * framePeriod;

	typedef struct packed {
		direction_t button;
		int holdMin;
		logic moves;
		int expX;
		int expY;
	} pathRow_t;

	`include "mazeGameTbTable.svh"

	logic clk;
	logic reset;
	logic left;
	logic up;
	logic right;
	logic down;
	pixel_t pix;
	logic plot;

	// last block drawn as rebuilt from plotted groups
	int modelX;
	int modelY;
	direction_t activeDir;
	logic allowHome;
	int homeGroups;
	int plotIndex;
	int gx [4];
	int gy [4];
	int gc [4];
	logic [31:0] rngState;

	mazeGame #(
		.framePeriod(framePeriod)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.left(left),
		.up(up),
		.right(right),
		.down(down),
		.pix(pix),
		.plot(plot)
	);

	always #50 clk = ~clk;

	task automatic stopWithError(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			stopWithError($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual,
				expected));
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic driveButton(input direction_t dir, input logic level);
		case (dir)
			dirLeft: left = level;
			dirUp: up = level;
			dirRight: right = level;
			dirDown: down = level;
			default: stopWithError("table row names no button");
		endcase
	endtask

	// true when the group is the red block at home, in raster order
	function automatic logic isHomeGroup();
		logic same;
		same = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (gx[i] != int'(homeX) + i % 2 || gy[i] != int'(homeY) + i / 2 ||
					gc[i] != int'(colorBlock)) begin
				same = 1'b0;
			end
		end
		return same;
	endfunction

	task automatic matchHome();
		for (int i = 0; i < 4; i++) begin
			checkValue("pix.x", gx[i], int'(homeX) + i % 2);
			checkValue("pix.y", gy[i], int'(homeY) + i / 2);
			checkValue("pix.color", gc[i], int'(colorBlock));
		end
		homeGroups++;
	endtask

	// one pixel step then leading edge red and vacated edge white
	task automatic stepModel();
		logic horizontal;
		int leadPos;
		int trailPos;
		int along;
		int across [4];
		int base;
		int lowSide;
		int highSide;
		string alongName;
		string acrossName;
		horizontal = (activeDir == dirLeft) || (activeDir == dirRight);
		case (activeDir)
			dirRight: begin
				modelX = modelX + 1;
				leadPos = modelX + 1;
				trailPos = modelX - 1;
			end
			dirLeft: begin
				modelX = modelX - 1;
				leadPos = modelX;
				trailPos = modelX + 2;
			end
			dirDown: begin
				modelY = modelY + 1;
				leadPos = modelY + 1;
				trailPos = modelY - 1;
			end
			default: begin
				// up is toward row 0
				modelY = modelY - 1;
				leadPos = modelY;
				trailPos = modelY + 2;
			end
		endcase
		alongName = horizontal ? "pix.x" : "pix.y";
		acrossName = horizontal ? "pix.y" : "pix.x";
		base = horizontal ? modelY : modelX;
		for (int i = 0; i < 4; i++) begin
			along = horizontal ? gx[i] : gy[i];
			across[i] = horizontal ? gy[i] : gx[i];
			checkValue("pix.color", gc[i], (i < 2) ? int'(colorBlock) : int'(colorErase));
			checkValue(alongName, along, (i < 2) ? leadPos : trailPos);
		end
		// each pair covers both rows or columns of the block
		for (int p = 0; p < 4; p += 2) begin
			lowSide = (across[p] < across[p + 1]) ? across[p] : across[p + 1];
			highSide = (across[p] < across[p + 1]) ? across[p + 1] : across[p];
			checkValue(acrossName, lowSide, base);
			checkValue(acrossName, highSide, base + 1);
		end
	endtask

	// plot and pix are registered so the falling edge sees settled values
	always @(negedge clk) begin
		if (!reset && plot) begin
			if (!allowHome && activeDir == dirNone) begin
				stopWithError("a pixel was plotted while the block was parked away from home");
			end else begin
				gx[plotIndex] = int'(pix.x);
				gy[plotIndex] = int'(pix.y);
				gc[plotIndex] = int'(pix.color);
				if (plotIndex == 3) begin
					plotIndex = 0;
					if (allowHome && (isHomeGroup() || activeDir == dirNone)) begin
						matchHome();
					end else begin
						allowHome = 1'b0;
						stepModel();
					end
				end else begin
					plotIndex++;
				end
			end
		end
	end

	task automatic waitForCorner(input int x, input int y);
		int cycles;
		cycles = 0;
		while (modelX != x || modelY != y) begin
			if (cycles >= moveTimeout) begin
				stopWithError("timeout: the block never reached the expected corner");
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	task automatic waitForHomeGroup();
		int target;
		int cycles;
		target = homeGroups + 1;
		cycles = 0;
		while (homeGroups < target) begin
			if (cycles >= 4 * framePeriod) begin
				stopWithError("timeout: no home block was drawn");
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	initial begin
		pathRow_t row;
		int holdCycles;
		clk = 1'b0;
		reset = 1'b1;
		left = 1'b0;
		up = 1'b0;
		right = 1'b0;
		down = 1'b0;
		modelX = int'(homeX);
		modelY = int'(homeY);
		activeDir = dirNone;
		allowHome = 1'b1;
		homeGroups = 0;
		plotIndex = 0;
		rngState = 32'h3669;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		// first frame after reset paints the home block
		waitForHomeGroup();
		for (int r = 0; r < rowCount; r++) begin
			row = pathTable[r];
			rngState = xorshift(rngState);
			holdCycles = row.holdMin + int'(rngState % 32'd24);
			@(negedge clk);
			driveButton(row.button, 1'b1);
			// no step may show up while the button is down
			repeat (holdCycles) @(negedge clk);
			driveButton(row.button, 1'b0);
			if (row.moves) begin
				activeDir = row.button;
				waitForCorner(row.expX, row.expY);
			end
			activeDir = dirNone;
			if (row.expX == int'(homeX) && row.expY == int'(homeY)) begin
				allowHome = 1'b1;
				waitForHomeGroup();
			end else begin
				// quiet window where the monitor flags any plot
				repeat (3 * framePeriod) @(negedge clk);
			end
			checkValue("block x", modelX, row.expX);
			checkValue("block y", modelY, row.expY);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
mazePkg.sv
pixelPkg.sv
frameTimer.sv
mazeNavigator.sv
blockDrawer.sv
mazeGame.sv
mazeGameTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the maze game testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f compile.f --top-module mazeGameTb -o mazeGameSim

# the simulation status is not trusted, the log decides
./obj_dir/mazeGameSim | tee sim.log

grep -q "Regression passed" sim.log
echo "simulation finished without errors"
